// File: src/sys_pkg.sv
`default_nettype none

package sys_pkg;

    // Field widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int FUNCT3_W   = 3;
    localparam int TAG_W      = 4;
    localparam int RETIRED_W  = 2;
    localparam int OPCODE_W   = 7;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [FUNCT3_W-1:0]   funct3_t;
    typedef logic [TAG_W-1:0]      tag_t;       // Register status, passed through
    typedef logic [RETIRED_W-1:0]  retired_count_t;

    localparam logic [OPCODE_W-1:0] OPCODE_SYSTEM = 7'b1110011;

    // SYSTEM funct3 codes, 3'b100 is left undefined
    localparam funct3_t FUNCT3_ENV    = 3'b000; // ECALL, EBREAK and friends
    localparam funct3_t FUNCT3_CSRRW  = 3'b001;
    localparam funct3_t FUNCT3_CSRRS  = 3'b010;
    localparam funct3_t FUNCT3_CSRRC  = 3'b011;
    localparam funct3_t FUNCT3_CSRRWI = 3'b101;
    localparam funct3_t FUNCT3_CSRRSI = 3'b110;
    localparam funct3_t FUNCT3_CSRRCI = 3'b111;

    // User-level counter CSRs
    localparam csr_addr_t CSR_CYCLE    = 12'hC00;
    localparam csr_addr_t CSR_TIME     = 12'hC01;
    localparam csr_addr_t CSR_INSTRET  = 12'hC02;
    localparam csr_addr_t CSR_CYCLEH   = 12'hC80;
    localparam csr_addr_t CSR_TIMEH    = 12'hC81;
    localparam csr_addr_t CSR_INSTRETH = 12'hC82;

endpackage

`default_nettype wire

// File: src/sys_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module sys_cmd_decoder (
    input  logic               clk,
    input  logic               rst,

    input  logic               instr_valid,
    output logic               instr_ready,
    input  sys_pkg::word_t     instr,
    input  sys_pkg::tag_t      instr_tag,
    input  logic               instr_jump,

    output logic               cmd_valid,
    input  logic               cmd_ready,
    output sys_pkg::reg_addr_t cmd_rd,
    output sys_pkg::funct3_t   cmd_funct3,
    output sys_pkg::csr_addr_t cmd_csr,
    output sys_pkg::tag_t      cmd_tag,
    output logic               cmd_jump
);

    import sys_pkg::*;

    logic      is_system;
    reg_addr_t instr_rd;
    funct3_t   instr_funct3;
    csr_addr_t instr_csr;

    // I-type field extraction
    assign is_system    = (instr[OPCODE_W-1:0] == OPCODE_SYSTEM);
    assign instr_rd     = instr[11:7];
    assign instr_funct3 = instr[14:12];
    assign instr_csr    = instr[31:20];

    // Empty or draining this cycle
    assign instr_ready = !cmd_valid || cmd_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid <= 1'b0;
        end else if (instr_ready) begin
            cmd_valid <= instr_valid && is_system; // Other opcodes are dropped
        end
    end

    // Payload only loads on an accepted SYSTEM word
    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready && is_system) begin
            cmd_rd     <= instr_rd;
            cmd_funct3 <= instr_funct3;
            cmd_csr    <= instr_csr;
            cmd_tag    <= instr_tag;
            cmd_jump   <= instr_jump;
        end
    end

endmodule

`default_nettype wire

// File: src/sys_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sys_cmd_fifo #(
    parameter int DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  sys_pkg::reg_addr_t cmd_rd,
    input  sys_pkg::funct3_t   cmd_funct3,
    input  sys_pkg::csr_addr_t cmd_csr,
    input  sys_pkg::tag_t      cmd_tag,
    input  logic               cmd_jump,

    output logic               q_valid,
    input  logic               q_ready,
    output sys_pkg::reg_addr_t q_rd,
    output sys_pkg::funct3_t   q_funct3,
    output sys_pkg::csr_addr_t q_csr,
    output sys_pkg::tag_t      q_tag,
    output logic               q_jump
);

    import sys_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    // Storage, one array per field
    reg_addr_t mem_rd     [DEPTH];
    funct3_t   mem_funct3 [DEPTH];
    csr_addr_t mem_csr    [DEPTH];
    tag_t      mem_tag    [DEPTH];
    logic      mem_jump   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;     // Occupancy, 0 to DEPTH
    logic             full;
    logic             do_write;
    logic             do_read;

    assign full      = (count == (PTR_W+1)'(DEPTH));
    assign q_valid   = (count != '0);
    assign cmd_ready = !full || q_ready; // Full FIFO may pass through on a read

    assign do_write = cmd_valid && cmd_ready;
    assign do_read  = q_valid && q_ready;

    // Head entry drives the output
    assign q_rd     = mem_rd[rd_ptr];
    assign q_funct3 = mem_funct3[rd_ptr];
    assign q_csr    = mem_csr[rd_ptr];
    assign q_tag    = mem_tag[rd_ptr];
    assign q_jump   = mem_jump[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps, DEPTH is a power of two
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem_rd[wr_ptr]     <= cmd_rd;
            mem_funct3[wr_ptr] <= cmd_funct3;
            mem_csr[wr_ptr]    <= cmd_csr;
            mem_tag[wr_ptr]    <= cmd_tag;
            mem_jump[wr_ptr]   <= cmd_jump;
        end
    end

endmodule

`default_nettype wire

// File: src/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
    input  logic                    clk,
    input  logic                    rst,
    input  sys_pkg::retired_count_t retired,
    output sys_pkg::word_t          cycle_lo,
    output sys_pkg::word_t          cycle_hi,
    output sys_pkg::word_t          instret_lo,
    output sys_pkg::word_t          instret_hi
);

    import sys_pkg::*;

    word_t cycle_partial;
    word_t instret_partial;
    logic  cycle_carry;
    logic  instret_carry;

    // Each half gets its own 32-bit adder, the carry crosses on a register
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_partial   <= '0;
            instret_partial <= '0;
            cycle_carry     <= 1'b0;
            instret_carry   <= 1'b0;
            cycle_lo        <= '0;
            cycle_hi        <= '0;
            instret_lo      <= '0;
            instret_hi      <= '0;
        end else begin
            // Low half adders
            {cycle_carry, cycle_partial}     <= {1'b0, cycle_partial} + 1'b1;
            {instret_carry, instret_partial} <= {1'b0, instret_partial} +
                                                (WORD_W+1)'(retired);

            // Low half lags the partial by a cycle
            cycle_lo   <= cycle_partial;
            instret_lo <= instret_partial;

            // High half picks up the carry, aligned with the low half
            cycle_hi   <= cycle_hi + WORD_W'(cycle_carry);
            instret_hi <= instret_hi + WORD_W'(instret_carry);
        end
    end

endmodule

`default_nettype wire

// File: src/sys_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module sys_csr_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  sys_pkg::retired_count_t retired,

    input  logic                    q_valid,
    output logic                    q_ready,
    input  sys_pkg::reg_addr_t      q_rd,
    input  sys_pkg::funct3_t        q_funct3,
    input  sys_pkg::csr_addr_t      q_csr,
    input  sys_pkg::tag_t           q_tag,
    input  logic                    q_jump,

    output logic                    result_valid,
    input  logic                    result_ready,
    output sys_pkg::reg_addr_t      result_addr,
    output sys_pkg::word_t          result_value,
    output sys_pkg::tag_t           result_tag,
    output logic                    result_jump
);

    import sys_pkg::*;

    word_t cycle_lo;
    word_t cycle_hi;
    word_t instret_lo;
    word_t instret_hi;
    word_t csr_value;
    logic  produce;
    logic  consume;

    perf_counters u_counters (
        .clk        (clk),
        .rst        (rst),
        .retired    (retired),
        .cycle_lo   (cycle_lo),
        .cycle_hi   (cycle_hi),
        .instret_lo (instret_lo),
        .instret_hi (instret_hi)
    );

    // Counter read, writes to the counters are not supported
    always_comb begin
        case (q_csr)
            CSR_CYCLE:    csr_value = cycle_lo;
            CSR_TIME:     csr_value = cycle_lo;  // Same clock as CYCLE
            CSR_INSTRET:  csr_value = instret_lo;
            CSR_CYCLEH:   csr_value = cycle_hi;
            CSR_TIMEH:    csr_value = cycle_hi;
            CSR_INSTRETH: csr_value = instret_hi;
            default:      csr_value = '0;
        endcase
    end

    // Writeback decision
    always_comb begin
        case (q_funct3)
            FUNCT3_CSRRW,
            FUNCT3_CSRRS,
            FUNCT3_CSRRC,
            FUNCT3_CSRRWI,
            FUNCT3_CSRRSI,
            FUNCT3_CSRRCI: produce = (q_rd != '0); // Nothing for x0
            FUNCT3_ENV:    produce = 1'b0;
            default:       produce = 1'b0;         // Undefined code
        endcase
    end

    // Result register free or being drained
    assign q_ready = !result_valid || result_ready;
    assign consume = q_valid && q_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (q_ready) begin
            result_valid <= q_valid && produce;
        end
    end

    always_ff @(posedge clk) begin
        if (consume && produce) begin
            result_addr  <= q_rd;
            result_value <= csr_value;
            result_tag   <= q_tag;
            result_jump  <= q_jump;
        end
    end

endmodule

`default_nettype wire

// File: src/sys_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module sys_subsystem (
    input  logic                    clk,
    input  logic                    rst,
    input  sys_pkg::retired_count_t retired,

    input  logic                    instr_valid,
    output logic                    instr_ready,
    input  sys_pkg::word_t          instr,
    input  sys_pkg::tag_t           instr_tag,
    input  logic                    instr_jump,

    output logic                    result_valid,
    input  logic                    result_ready,
    output sys_pkg::reg_addr_t      result_addr,
    output sys_pkg::word_t          result_value,
    output sys_pkg::tag_t           result_tag,
    output logic                    result_jump
);

    import sys_pkg::*;

    // Decoder to FIFO
    logic      cmd_valid;
    logic      cmd_ready;
    reg_addr_t cmd_rd;
    funct3_t   cmd_funct3;
    csr_addr_t cmd_csr;
    tag_t      cmd_tag;
    logic      cmd_jump;

    // FIFO to CSR unit
    logic      q_valid;
    logic      q_ready;
    reg_addr_t q_rd;
    funct3_t   q_funct3;
    csr_addr_t q_csr;
    tag_t      q_tag;
    logic      q_jump;

    sys_cmd_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .instr_tag   (instr_tag),
        .instr_jump  (instr_jump),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_rd      (cmd_rd),
        .cmd_funct3  (cmd_funct3),
        .cmd_csr     (cmd_csr),
        .cmd_tag     (cmd_tag),
        .cmd_jump    (cmd_jump)
    );

    sys_cmd_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_rd     (cmd_rd),
        .cmd_funct3 (cmd_funct3),
        .cmd_csr    (cmd_csr),
        .cmd_tag    (cmd_tag),
        .cmd_jump   (cmd_jump),
        .q_valid    (q_valid),
        .q_ready    (q_ready),
        .q_rd       (q_rd),
        .q_funct3   (q_funct3),
        .q_csr      (q_csr),
        .q_tag      (q_tag),
        .q_jump     (q_jump)
    );

    sys_csr_unit u_csr (
        .clk          (clk),
        .rst          (rst),
        .retired      (retired),
        .q_valid      (q_valid),
        .q_ready      (q_ready),
        .q_rd         (q_rd),
        .q_funct3     (q_funct3),
        .q_csr        (q_csr),
        .q_tag        (q_tag),
        .q_jump       (q_jump),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_addr  (result_addr),
        .result_value (result_value),
        .result_tag   (result_tag),
        .result_jump  (result_jump)
    );

endmodule

`default_nettype wire

// File: sim/sys_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sys_subsystem_tb;

    import sys_pkg::*;

    localparam int N_ROWS         = 16;
    localparam int TIMEOUT_CYCLES = 40 * N_ROWS + 200;
    localparam int N_PRELOAD      = 10;

    // Expected value kinds
    localparam int KIND_INSTRET = 0;
    localparam int KIND_ZERO    = 1;
    localparam int KIND_CYCLE   = 2;

    logic           clk;
    logic           rst;
    retired_count_t retired;
    logic           instr_valid;
    logic           instr_ready;
    word_t          instr;
    tag_t           instr_tag;
    logic           instr_jump;
    logic           result_valid;
    logic           result_ready;
    reg_addr_t      result_addr;
    word_t          result_value;
    tag_t           result_tag;
    logic           result_jump;

    // Stimulus table, one row per instruction
    logic [6:0] row_opcode [N_ROWS];
    reg_addr_t  row_rd     [N_ROWS];
    funct3_t    row_funct3 [N_ROWS];
    csr_addr_t  row_csr    [N_ROWS];
    tag_t       row_tag    [N_ROWS];
    logic       row_jump   [N_ROWS];
    logic       row_expect [N_ROWS];
    int         row_kind   [N_ROWS];
    int         row_count;

    int     expected_q[$];     // Row indices of pending results
    integer seed;
    int     error_count;
    int     results_seen;
    int     results_expected;
    int     cycle_count;
    int     cycles_since_reset;
    word_t  instret_sum;
    word_t  prev_cycle;

    sys_subsystem dut (
        .clk          (clk),
        .rst          (rst),
        .retired      (retired),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .instr_tag    (instr_tag),
        .instr_jump   (instr_jump),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_addr  (result_addr),
        .result_value (result_value),
        .result_tag   (result_tag),
        .result_jump  (result_jump)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (!rst) begin
            cycles_since_reset++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d results still pending", cycle_count,
                     expected_q.size());
            $display("Results seen: %0d, errors: %0d", results_seen, error_count + 1);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic add_row(input logic [6:0] opcode, input reg_addr_t rd,
                           input funct3_t funct3, input csr_addr_t csr, input tag_t tag,
                           input logic jump, input logic expect_result, input int kind);
        row_opcode[row_count] = opcode;
        row_rd[row_count]     = rd;
        row_funct3[row_count] = funct3;
        row_csr[row_count]    = csr;
        row_tag[row_count]    = tag;
        row_jump[row_count]   = jump;
        row_expect[row_count] = expect_result;
        row_kind[row_count]   = kind;
        row_count++;
    endtask

    task automatic load_table();
        row_count = 0;
        add_row(OPCODE_SYSTEM, 5'd5,  FUNCT3_CSRRS,  CSR_INSTRET,  4'h1, 1'b0, 1'b1, KIND_INSTRET);
        add_row(OPCODE_SYSTEM, 5'd6,  FUNCT3_CSRRS,  CSR_CYCLE,    4'h2, 1'b1, 1'b1, KIND_CYCLE);
        add_row(OPCODE_SYSTEM, 5'd7,  FUNCT3_CSRRS,  CSR_TIME,     4'h3, 1'b0, 1'b1, KIND_CYCLE);
        add_row(OPCODE_SYSTEM, 5'd0,  FUNCT3_CSRRS,  CSR_CYCLE,    4'h4, 1'b0, 1'b0, KIND_ZERO);
        add_row(OPCODE_SYSTEM, 5'd8,  FUNCT3_ENV,    12'h000,      4'h5, 1'b0, 1'b0, KIND_ZERO);
        add_row(OPCODE_SYSTEM, 5'd9,  3'b100,        CSR_CYCLE,    4'h6, 1'b1, 1'b0, KIND_ZERO);
        add_row(7'b0010011,    5'd10, FUNCT3_CSRRS,  CSR_CYCLE,    4'h7, 1'b0, 1'b0, KIND_ZERO);
        add_row(OPCODE_SYSTEM, 5'd11, FUNCT3_CSRRW,  CSR_INSTRETH, 4'h8, 1'b1, 1'b1, KIND_ZERO);
        add_row(OPCODE_SYSTEM, 5'd12, FUNCT3_CSRRC,  CSR_CYCLEH,   4'h9, 1'b0, 1'b1, KIND_ZERO);
        add_row(OPCODE_SYSTEM, 5'd13, FUNCT3_CSRRWI, CSR_TIMEH,    4'hA, 1'b1, 1'b1, KIND_ZERO);
        add_row(OPCODE_SYSTEM, 5'd14, FUNCT3_CSRRSI, 12'h300,      4'hB, 1'b0, 1'b1, KIND_ZERO);
        add_row(OPCODE_SYSTEM, 5'd15, FUNCT3_CSRRCI, CSR_INSTRET,  4'hC, 1'b1, 1'b1, KIND_INSTRET);
        add_row(OPCODE_SYSTEM, 5'd31, FUNCT3_CSRRS,  CSR_TIME,     4'hD, 1'b0, 1'b1, KIND_CYCLE);
        add_row(OPCODE_SYSTEM, 5'd1,  FUNCT3_ENV,    12'h001,      4'hE, 1'b0, 1'b0, KIND_ZERO);
        add_row(OPCODE_SYSTEM, 5'd16, FUNCT3_CSRRS,  12'hC03,      4'hF, 1'b1, 1'b1, KIND_ZERO);
        add_row(OPCODE_SYSTEM, 5'd17, FUNCT3_CSRRS,  CSR_CYCLE,    4'h0, 1'b0, 1'b1, KIND_CYCLE);
    endtask

    // I-type layout, rs1 carries the row index
    function automatic word_t build_instr(input int r);
        reg_addr_t rs1;
        rs1 = reg_addr_t'(r);
        return {row_csr[r], rs1, row_funct3[r], row_rd[r], row_opcode[r]};
    endfunction

    // Advance to drive time, result_ready stalls at random
    task automatic next_cycle();
        @(posedge clk);
        #1;
        result_ready = ($unsigned($random(seed)) % 4) != 0;
    endtask

    task automatic check_idle();
        if (instr_ready !== 1'b1) begin
            $display("Mismatch after reset instr_ready: got 0x%h expected 0x1", instr_ready);
            error_count++;
        end
        if (result_valid !== 1'b0) begin
            $display("Mismatch after reset result_valid: got 0x%h expected 0x0", result_valid);
            error_count++;
        end
    endtask

    task automatic preload_instret();
        retired_count_t preload_list [N_PRELOAD];
        preload_list = '{2'd3, 2'd1, 2'd2, 2'd0, 2'd3, 2'd3, 2'd1, 2'd2, 2'd0, 2'd3};
        instret_sum = '0;
        for (int i = 0; i < N_PRELOAD; i++) begin
            retired     = preload_list[i];
            instret_sum = instret_sum + word_t'(preload_list[i]);
            next_cycle();
        end
        retired = '0;
        repeat (4) next_cycle(); // Let the counter pipeline settle
    endtask

    task automatic send_row(input int r);
        int   gap;
        logic accepted;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) next_cycle();
        instr       = build_instr(r);
        instr_tag   = row_tag[r];
        instr_jump  = row_jump[r];
        instr_valid = 1'b1;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = instr_ready; // Transfer on the coming edge
            next_cycle();
        end
        instr_valid = 1'b0;
        if (row_expect[r]) begin
            expected_q.push_back(r);
            results_expected++;
        end
    endtask

    task automatic check_result();
        int r;
        results_seen++;
        if (expected_q.size() == 0) begin
            $display("Result for x%0d arrived while no result was expected", result_addr);
            error_count++;
        end else begin
            r = expected_q.pop_front();
            if (result_addr !== row_rd[r]) begin
                $display("Mismatch row %0d result_addr: got 0x%h expected 0x%h",
                         r, result_addr, row_rd[r]);
                error_count++;
            end
            if (result_tag !== row_tag[r]) begin
                $display("Mismatch row %0d result_tag: got 0x%h expected 0x%h",
                         r, result_tag, row_tag[r]);
                error_count++;
            end
            if (result_jump !== row_jump[r]) begin
                $display("Mismatch row %0d result_jump: got 0x%h expected 0x%h",
                         r, result_jump, row_jump[r]);
                error_count++;
            end
            if (row_kind[r] == KIND_INSTRET && result_value !== instret_sum) begin
                $display("Mismatch row %0d result_value: got 0x%h expected 0x%h",
                         r, result_value, instret_sum);
                error_count++;
            end
            if (row_kind[r] == KIND_ZERO && result_value !== '0) begin
                $display("Mismatch row %0d result_value: got 0x%h expected 0x0",
                         r, result_value);
                error_count++;
            end
            if (row_kind[r] == KIND_CYCLE) begin
                if (result_value <= prev_cycle) begin
                    $display("Row %0d clock read 0x%h is not above the previous read 0x%h",
                             r, result_value, prev_cycle);
                    error_count++;
                end
                if (result_value > word_t'(cycles_since_reset)) begin
                    $display("Row %0d clock read 0x%h is ahead of the %0d cycles since reset",
                             r, result_value, cycles_since_reset);
                    error_count++;
                end
                prev_cycle = result_value;
            end
        end
    endtask

    // Handshake completes on the next rising edge
    always @(negedge clk) begin
        if (!rst && result_valid && result_ready) begin
            check_result();
        end
    end

    initial begin
        seed               = 16;
        clk                = 1'b0;
        rst                = 1'b1;
        retired            = '0;
        instr_valid        = 1'b0;
        instr              = '0;
        instr_tag          = '0;
        instr_jump         = 1'b0;
        result_ready       = 1'b1;
        error_count        = 0;
        results_seen       = 0;
        results_expected   = 0;
        cycle_count        = 0;
        cycles_since_reset = 0;
        instret_sum        = '0;
        prev_cycle         = '0;
        load_table();

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_idle();
        preload_instret();

        for (int i = 0; i < row_count; i++) begin
            send_row(i);
        end
        while (expected_q.size() != 0) begin
            next_cycle();
        end
        repeat (10) next_cycle(); // Catch stray extra results

        if (results_seen != results_expected) begin
            $display("Saw %0d results where %0d were expected", results_seen, results_expected);
            error_count++;
        end
        $display("Results seen: %0d of %0d, errors: %0d", results_seen, results_expected,
                 error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sys_subsystem.f
src/sys_pkg.sv
src/sys_cmd_decoder.sv
src/sys_cmd_fifo.sv
src/perf_counters.sv
src/sys_csr_unit.sv
src/sys_subsystem.sv
sim/sys_subsystem_tb.sv

// File: Bender.yml
package:
  name: sys_subsystem

sources:
  - files:
      - src/sys_pkg.sv
      - src/sys_cmd_decoder.sv
      - src/sys_cmd_fifo.sv
      - src/perf_counters.sv
      - src/sys_csr_unit.sv
      - src/sys_subsystem.sv
  - target: simulation
    files:
      - sim/sys_subsystem_tb.sv
